// File: hw/fpFormatPkg.sv
package fpFormatPkg;

  typedef enum logic [1:0] {
    fmtSingle     = 2'd0,
    fmtDouble     = 2'd1,
    fmtPairSingle = 2'd2
  } fpFmtE;

  // double precision register
  localparam int OperandWidth = 64;
  localparam int ExpWidth     = 11;
  localparam int FracWidth    = 52;

  // single precision fields, one per lane
  localparam int SglExpWidth  = 8;
  localparam int SglFracWidth = 23;

  localparam int LaneCount = 2;
  localparam int LaneWidth = OperandWidth / LaneCount;

  typedef logic [OperandWidth-1:0] operandT;
  typedef logic [ExpWidth-1:0]     expT;      // single exp zero-extended
  typedef logic [FracWidth-1:0]    fracT;     // single frac left-aligned

endpackage

// File: hw/cmpOpPkg.sv
package cmpOpPkg;

  typedef enum logic [1:0] {
    opCmpScalar = 2'd0,
    opCmpVector = 2'd1,
    opSearch    = 2'd2
  } cmpOpE;

  // lane mask condition
  typedef enum logic [1:0] {
    condGe  = 2'd0,
    condNge = 2'd1,
    condEq  = 2'd2,
    condNe  = 2'd3
  } condE;

  typedef logic [1:0] srchSzT;  // 8 << code bits per element

  localparam int FlagWidth   = 6;
  localparam int FlagGe      = 5;
  localparam int FlagUnordHi = 4;
  localparam int FlagLt      = 2;
  localparam int FlagEq      = 1;
  localparam int FlagUnord   = 0;

  localparam int ResultWidth = 64;

  typedef logic [FlagWidth-1:0]   flagsT;
  typedef logic [ResultWidth-1:0] resultT;

endpackage

// File: hw/fcmpIf.sv
`timescale 1ns/1ps

interface fcmpOpIf;
  logic valid;
  logic ready;

  // per lane classified fields
  logic [fpFormatPkg::LaneCount-1:0] signA;
  logic [fpFormatPkg::LaneCount-1:0] signB;
  fpFormatPkg::expT [fpFormatPkg::LaneCount-1:0] expA;
  fpFormatPkg::expT [fpFormatPkg::LaneCount-1:0] expB;
  fpFormatPkg::fracT [fpFormatPkg::LaneCount-1:0] fracA;
  fpFormatPkg::fracT [fpFormatPkg::LaneCount-1:0] fracB;
  logic [fpFormatPkg::LaneCount-1:0] zeroA;
  logic [fpFormatPkg::LaneCount-1:0] zeroB;
  logic [fpFormatPkg::LaneCount-1:0] nanA;
  logic [fpFormatPkg::LaneCount-1:0] nanB;

  fpFormatPkg::operandT rawA;  // for search
  fpFormatPkg::fpFmtE fmt;
  cmpOpPkg::cmpOpE op;
  cmpOpPkg::condE cond;
  cmpOpPkg::srchSzT srchSz;

  modport src(output valid, signA, signB, expA, expB, fracA, fracB, zeroA, zeroB,
              nanA, nanB, rawA, fmt, op, cond, srchSz, input ready);
  modport dst(input valid, signA, signB, expA, expB, fracA, fracB, zeroA, zeroB,
              nanA, nanB, rawA, fmt, op, cond, srchSz, output ready);
endinterface

interface fcmpClassIf;
  logic valid;
  logic ready;
  cmpOpPkg::resultT data;
  cmpOpPkg::flagsT flags;

  modport src(output valid, data, flags, input ready);
  modport dst(input valid, data, flags, output ready);
endinterface

// File: hw/bitFindFirst.sv
`timescale 1ns/1ps

module bitFindFirst #(
  parameter int Width = 8
) (
  input  logic [Width-1:0]         bits,
  output logic [$clog2(Width)-1:0] index,
  output logic                     found
);

  always_comb begin
    index = '0;
    found = 1'b0;
    // scan downward so the lowest set bit is written last
    for (int i = Width - 1; i >= 0; i--) begin
      if (bits[i]) begin
        index = ($clog2(Width))'(i);
        found = 1'b1;
      end
    end
  end

endmodule

// File: hw/fcmpOperandUnpack.sv
`timescale 1ns/1ps

module fcmpOperandUnpack (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  output logic                 inReady,
  input  fpFormatPkg::operandT opA,
  input  fpFormatPkg::operandT opB,
  input  fpFormatPkg::fpFmtE   fmt,
  input  cmpOpPkg::cmpOpE      op,
  input  cmpOpPkg::condE       cond,
  input  cmpOpPkg::srchSzT     srchSz,
  fcmpOpIf.src                 opOut
);

  logic [fpFormatPkg::LaneCount-1:0] signA, signB;
  fpFormatPkg::expT [fpFormatPkg::LaneCount-1:0] expA, expB;
  fpFormatPkg::fracT [fpFormatPkg::LaneCount-1:0] fracA, fracB;
  logic [fpFormatPkg::LaneCount-1:0] zeroA, zeroB;
  logic [fpFormatPkg::LaneCount-1:0] nanA, nanB;
  logic load;

  function automatic void splitSingle(
    input  logic [fpFormatPkg::LaneWidth-1:0] w,
    output logic                              s,
    output fpFormatPkg::expT                  e,
    output fpFormatPkg::fracT                 f
  );
    logic [fpFormatPkg::SglExpWidth-1:0] e8;
    e8 = w[fpFormatPkg::SglFracWidth +: fpFormatPkg::SglExpWidth];
    s = w[fpFormatPkg::LaneWidth-1];
    e = (&e8) ? '1 : fpFormatPkg::expT'(e8);  // keep inf/nan exponent all ones
    f = {w[fpFormatPkg::SglFracWidth-1:0],
         {(fpFormatPkg::FracWidth - fpFormatPkg::SglFracWidth){1'b0}}};
  endfunction

  always_comb begin
    for (int l = 0; l < fpFormatPkg::LaneCount; l++) begin
      splitSingle(opA[l*fpFormatPkg::LaneWidth +: fpFormatPkg::LaneWidth],
                  signA[l], expA[l], fracA[l]);
      splitSingle(opB[l*fpFormatPkg::LaneWidth +: fpFormatPkg::LaneWidth],
                  signB[l], expB[l], fracB[l]);
    end
    if (fmt == fpFormatPkg::fmtDouble) begin  // lane 0 takes the whole register
      signA[0] = opA[fpFormatPkg::OperandWidth-1];
      expA[0]  = opA[fpFormatPkg::FracWidth +: fpFormatPkg::ExpWidth];
      fracA[0] = opA[fpFormatPkg::FracWidth-1:0];
      signB[0] = opB[fpFormatPkg::OperandWidth-1];
      expB[0]  = opB[fpFormatPkg::FracWidth +: fpFormatPkg::ExpWidth];
      fracB[0] = opB[fpFormatPkg::FracWidth-1:0];
    end
    for (int l = 0; l < fpFormatPkg::LaneCount; l++) begin
      zeroA[l] = (expA[l] == '0) && (fracA[l] == '0);
      zeroB[l] = (expB[l] == '0) && (fracB[l] == '0);
      nanA[l]  = (&expA[l]) && (|fracA[l]);
      nanB[l]  = (&expB[l]) && (|fracB[l]);
    end
  end

  assign inReady = ~opOut.valid | opOut.ready;
  assign load    = inValid & inReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      opOut.valid <= 1'b0;
    end else if (inReady) begin
      opOut.valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      opOut.signA  <= signA;
      opOut.signB  <= signB;
      opOut.expA   <= expA;
      opOut.expB   <= expB;
      opOut.fracA  <= fracA;
      opOut.fracB  <= fracB;
      opOut.zeroA  <= zeroA;
      opOut.zeroB  <= zeroB;
      opOut.nanA   <= nanA;
      opOut.nanB   <= nanB;
      opOut.rawA   <= opA;
      opOut.fmt    <= fmt;
      opOut.op     <= op;
      opOut.cond   <= cond;
      opOut.srchSz <= srchSz;
    end
  end

endmodule

// File: hw/fcmpCore.sv
`timescale 1ns/1ps

module fcmpCore #(
  parameter bit HasSearch = 1'b1
) (
  input  logic clk,
  input  logic rst,
  fcmpOpIf.dst opIn,
  fcmpClassIf.src resOut
);

  localparam int SrchWidth = 8;
  localparam int IdxWidth  = $clog2(SrchWidth);
  localparam int HalfWidth = cmpOpPkg::ResultWidth / 2;

  cmpOpPkg::flagsT [fpFormatPkg::LaneCount-1:0] laneFlag;
  logic [fpFormatPkg::LaneCount-1:0] laneHit;
  logic hiHit;
  logic [IdxWidth-1:0] srchIdx;
  logic srchFound;
  cmpOpPkg::resultT nextData;
  cmpOpPkg::flagsT nextFlags;
  logic stageReady;

  function automatic cmpOpPkg::flagsT laneFlags(
    input logic              sA, sB,
    input fpFormatPkg::expT  eA, eB,
    input fpFormatPkg::fracT fA, fB,
    input logic              zA, zB, nA, nB
  );
    logic unord;
    logic eq;
    logic magLt;
    logic magGt;
    logic lt;
    cmpOpPkg::flagsT f;
    unord = nA | nB;
    magLt = {eA, fA} < {eB, fB};
    magGt = {eA, fA} > {eB, fB};
    eq    = ~unord & ((zA & zB) | ((sA == sB) & (eA == eB) & (fA == fB)));
    // negative magnitudes order backwards
    lt    = ~unord & ~eq & ((sA & ~sB) | (~sA & ~sB & magLt) | (sA & sB & magGt));
    f = '0;
    f[cmpOpPkg::FlagGe]      = ~(lt | unord);
    f[cmpOpPkg::FlagUnordHi] = unord;
    f[cmpOpPkg::FlagLt]      = lt;
    f[cmpOpPkg::FlagEq]      = eq;
    f[cmpOpPkg::FlagUnord]   = unord;
    return f;
  endfunction

  function automatic logic condHit(input cmpOpPkg::flagsT f, input cmpOpPkg::condE c);
    case (c)
      cmpOpPkg::condGe:  return f[cmpOpPkg::FlagGe];
      cmpOpPkg::condNge: return ~f[cmpOpPkg::FlagGe];
      cmpOpPkg::condEq:  return f[cmpOpPkg::FlagEq];
      default:           return ~f[cmpOpPkg::FlagEq];
    endcase
  endfunction

  if (HasSearch) begin : gSearch
    logic [SrchWidth-1:0] srchBits;

    always_comb begin
      srchBits = '0;
      case (opIn.srchSz)
        2'd0: for (int i = 0; i < 8; i++) srchBits[i] = opIn.rawA[8*i+7];
        2'd1: for (int i = 0; i < 4; i++) srchBits[i] = opIn.rawA[16*i+15];
        2'd2: for (int i = 0; i < 2; i++) srchBits[i] = opIn.rawA[32*i+31];
        default: srchBits[0] = opIn.rawA[63];
      endcase
    end

    bitFindFirst #(
      .Width(SrchWidth)
    ) i_bitFindFirst (
      .bits (srchBits),
      .index(srchIdx),
      .found(srchFound)
    );
  end else begin : gNoSearch
    assign srchIdx   = '0;
    assign srchFound = 1'b0;
  end

  always_comb begin
    for (int l = 0; l < fpFormatPkg::LaneCount; l++) begin
      laneFlag[l] = laneFlags(opIn.signA[l], opIn.signB[l], opIn.expA[l], opIn.expB[l],
                              opIn.fracA[l], opIn.fracB[l], opIn.zeroA[l], opIn.zeroB[l],
                              opIn.nanA[l], opIn.nanB[l]);
      laneHit[l]  = condHit(laneFlag[l], opIn.cond);
    end
    hiHit = (opIn.fmt == fpFormatPkg::fmtPairSingle) ? laneHit[1] : laneHit[0];
    nextFlags = laneFlag[0];
    case (opIn.op)
      cmpOpPkg::opCmpVector: nextData = {{HalfWidth{hiHit}}, {HalfWidth{laneHit[0]}}};
      cmpOpPkg::opSearch: begin
        nextData  = cmpOpPkg::resultT'(srchIdx);
        nextFlags = '0;
        nextFlags[cmpOpPkg::FlagGe] = srchFound;
      end
      default: nextData = {cmpOpPkg::ResultWidth{laneHit[0]}};
    endcase
  end

  assign stageReady = ~resOut.valid | resOut.ready;
  assign opIn.ready = stageReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      resOut.valid <= 1'b0;
    end else if (stageReady) begin
      resOut.valid <= opIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (opIn.valid && stageReady) begin
      resOut.data  <= nextData;
      resOut.flags <= nextFlags;
    end
  end

endmodule

// File: hw/fcmpResultPack.sv
`timescale 1ns/1ps

module fcmpResultPack (
  input  logic             clk,
  input  logic             rst,
  fcmpClassIf.dst          resIn,
  output logic             outValid,
  input  logic             outReady,
  output cmpOpPkg::resultT resData,
  output cmpOpPkg::flagsT  resFlags
);

  logic load;

  // free when empty or drained this cycle
  assign resIn.ready = ~outValid | outReady;
  assign load        = resIn.valid & resIn.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (resIn.ready) begin
      outValid <= resIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      resData  <= resIn.data;   // held while stalled
      resFlags <= resIn.flags;
    end
  end

endmodule

// File: hw/fcmpUnit.sv
`timescale 1ns/1ps

module fcmpUnit #(
  parameter bit HasSearch = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  output logic                 inReady,
  input  fpFormatPkg::operandT opA,
  input  fpFormatPkg::operandT opB,
  input  fpFormatPkg::fpFmtE   fmt,
  input  cmpOpPkg::cmpOpE      op,
  input  cmpOpPkg::condE       cond,
  input  cmpOpPkg::srchSzT     srchSz,
  output logic                 outValid,
  input  logic                 outReady,
  output cmpOpPkg::resultT     resData,
  output cmpOpPkg::flagsT      resFlags
);

  fcmpOpIf opLink ();
  fcmpClassIf resLink ();

  fcmpOperandUnpack i_fcmpOperandUnpack (
    .clk    (clk),
    .rst    (rst),
    .inValid(inValid),
    .inReady(inReady),
    .opA    (opA),
    .opB    (opB),
    .fmt    (fmt),
    .op     (op),
    .cond   (cond),
    .srchSz (srchSz),
    .opOut  (opLink.src)
  );

  fcmpCore #(
    .HasSearch(HasSearch)
  ) i_fcmpCore (
    .clk   (clk),
    .rst   (rst),
    .opIn  (opLink.dst),
    .resOut(resLink.src)
  );

  fcmpResultPack i_fcmpResultPack (
    .clk     (clk),
    .rst     (rst),
    .resIn   (resLink.dst),
    .outValid(outValid),
    .outReady(outReady),
    .resData (resData),
    .resFlags(resFlags)
  );

endmodule

// File: tb/fcmpUnitTb.sv
`timescale 1ns/1ps

module fcmpUnitTb;

  localparam int WaitLimit    = 50;
  localparam int TrafficCount = 60;
  localparam int TrafficLimit = 3000;

  logic clk, rst, inValid, inReady, outValid, outReady;
  fpFormatPkg::operandT opA, opB;
  fpFormatPkg::fpFmtE fmt;
  cmpOpPkg::cmpOpE op;
  cmpOpPkg::condE cond;
  cmpOpPkg::srchSzT srchSz;
  cmpOpPkg::resultT resData;
  cmpOpPkg::flagsT resFlags;

  int errors, checks, timeouts;
  logic [31:0] lfsr;
  logic [69:0] expQ[$];  // {flags, data} per accepted request

  fcmpUnit #(
    .HasSearch(1'b1)
  ) i_fcmpUnit (
    .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
    .opA(opA), .opB(opB), .fmt(fmt), .op(op), .cond(cond), .srchSz(srchSz),
    .outValid(outValid), .outReady(outReady), .resData(resData), .resFlags(resFlags)
  );

  always #5 clk = ~clk;

  function automatic logic lfsrBit();
    logic b;
    b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
    lfsr = {lfsr[30:0], b};
    return b;
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsrBit()};
    return v;
  endfunction

  function automatic cmpOpPkg::flagsT refFlags(input logic [63:0] a, input logic [63:0] b,
                                               input logic isDouble);
    logic sA, sB, nA, nB, un, eq, lt;
    logic [62:0] mA, mB;
    sA = isDouble ? a[63] : a[31];
    sB = isDouble ? b[63] : b[31];
    mA = isDouble ? a[62:0] : {32'd0, a[30:0]};
    mB = isDouble ? b[62:0] : {32'd0, b[30:0]};
    nA = isDouble ? (&a[62:52] && |a[51:0]) : (&a[30:23] && |a[22:0]);
    nB = isDouble ? (&b[62:52] && |b[51:0]) : (&b[30:23] && |b[22:0]);
    un = nA | nB;
    eq = !un && ((mA == 0 && mB == 0) || (sA == sB && mA == mB));  // +0 == -0
    lt = !un && !eq && ((sA != sB) ? sA : (sA ? (mA > mB) : (mA < mB)));
    return {~(lt | un), un, 1'b0, lt, eq, un};
  endfunction

  function automatic logic laneCond(input cmpOpPkg::flagsT f, input logic [1:0] c);
    case (c)
      2'd0: return f[5];
      2'd1: return ~f[5];
      2'd2: return f[1];
      default: return ~f[1];
    endcase
  endfunction

  function automatic logic [69:0] refResult(input logic [63:0] a, b, input logic [1:0] f,
                                            input logic [1:0] o, c, s);
    logic [63:0] d;
    logic [5:0] fl;
    int w;
    d = '0;
    fl = '0;
    if (o == 2'd2) begin
      w = 8 << s;
      for (int i = 64 / w - 1; i >= 0; i--) begin
        if (a[w*i + w - 1]) begin
          d = i;
          fl = 6'b100000;
        end
      end
    end else if (o == 2'd1) begin
      fl = refFlags({32'd0, a[31:0]}, {32'd0, b[31:0]}, 1'b0);
      d[31:0]  = {32{laneCond(fl, c)}};
      d[63:32] = {32{laneCond(refFlags({32'd0, a[63:32]}, {32'd0, b[63:32]}, 1'b0), c)}};
    end else begin
      fl = refFlags(a, b, f == 2'd1);
      d = {64{laneCond(fl, c)}};
    end
    return {fl, d};
  endfunction

  // 1.0 2.0 -1.0 +0 -0 -2.0 +inf -inf nan
  function automatic logic [63:0] sampleValue(input int i, input logic isDouble);
    case (i)
      0: return isDouble ? 64'h3ff0_0000_0000_0000 : 64'h3f80_0000;
      1: return isDouble ? 64'h4000_0000_0000_0000 : 64'h4000_0000;
      2: return isDouble ? 64'hbff0_0000_0000_0000 : 64'hbf80_0000;
      3: return 64'h0;
      4: return isDouble ? 64'h8000_0000_0000_0000 : 64'h8000_0000;
      5: return isDouble ? 64'hc000_0000_0000_0000 : 64'hc000_0000;
      6: return isDouble ? 64'h7ff0_0000_0000_0000 : 64'h7f80_0000;
      7: return isDouble ? 64'hfff0_0000_0000_0000 : 64'hff80_0000;
      default: return isDouble ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000;
    endcase
  endfunction

  task automatic checkHex(input string name, input logic [63:0] expVal, actVal);
    checks++;
    assert (actVal === expVal) else begin
      $display("** Error: %s expected %h, got %h", name, expVal, actVal);
      errors++;
    end
  endtask

  task automatic runCase(input logic [63:0] a, b, input logic [1:0] f, o, c, s);
    logic [69:0] exp;
    int waited;
    int lat;
    exp = refResult(a, b, f, o, c, s);
    @(posedge clk);
    inValid  <= 1'b1;
    outReady <= 1'b1;
    opA      <= a;
    opB      <= b;
    fmt      <= fpFormatPkg::fpFmtE'(f);
    op       <= cmpOpPkg::cmpOpE'(o);
    cond     <= cmpOpPkg::condE'(c);
    srchSz   <= s;
    waited = 0;
    @(negedge clk);
    while (!inReady && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    inValid <= 1'b0;
    if (!inReady) begin
      $display("timeout: request was not accepted within %0d cycles", WaitLimit);
      timeouts++;
    end else begin
      lat = 0;
      do begin
        @(negedge clk);
        lat++;
      end while (!outValid && lat < WaitLimit);
      if (!outValid) begin
        $display("timeout: no result came out within %0d cycles", WaitLimit);
        timeouts++;
      end else begin
        checkHex("latency", 64'd3, lat);
        checkHex("resData", exp[63:0], resData);
        checkHex("resFlags", exp[69:64], resFlags);
      end
    end
  endtask

  task automatic resetState();
    @(negedge clk);
    checkHex("outValid", 64'd0, outValid);
    checkHex("inReady", 64'd1, inReady);
  endtask

  task automatic scalarCompares();
    for (int d = 0; d < 2; d++)
      for (int i = 0; i < 6; i++)
        for (int j = 0; j < 6; j++)
          runCase(sampleValue(i, d), sampleValue(j, d), d, 2'd0, (i + j) % 4, 2'd0);
  endtask

  task automatic unorderedCases();
    for (int d = 0; d < 2; d++)
      for (int i = 0; i < 9; i++)
        for (int j = 6; j < 9; j++) begin
          runCase(sampleValue(i, d), sampleValue(j, d), d, 2'd0, 2'd3, 2'd0);
          runCase(sampleValue(j, d), sampleValue(i, d), d, 2'd0, 2'd0, 2'd0);
        end
  endtask

  task automatic vectorMasks();
    logic [63:0] a, b;
    for (int c = 0; c < 4; c++)
      for (int i = 0; i < 9; i++) begin
        a = {32'(sampleValue(i, 0)), 32'(sampleValue((i + 3) % 9, 0))};
        b = {32'(sampleValue((i + 1) % 9, 0)), 32'(sampleValue(i, 0))};
        runCase(a, b, 2'd2, 2'd1, c, 2'd0);
        runCase(a, a, 2'd2, 2'd1, c, 2'd0);
      end
  endtask

  task automatic searchCases();
    for (int s = 0; s < 4; s++) begin
      runCase(64'h0, 64'h0, 2'd0, 2'd2, 2'd0, s);  // nothing found
      runCase(64'h8000_8000_0080_0000, 64'h0, 2'd0, 2'd2, 2'd0, s);
      runCase(64'hffff_ffff_ffff_ffff, 64'h0, 2'd0, 2'd2, 2'd0, s);
      runCase(randBits(64), 64'h0, 2'd0, 2'd2, 2'd0, s);
    end
  endtask

  task automatic driveRandom();
    logic [1:0] o;
    logic [63:0] a;
    o = randBits(2) % 3;
    a = randBits(64);
    opA <= a;
    opB <= (randBits(2) == 0) ? a : randBits(64);  // some equal pairs
    op  <= cmpOpPkg::cmpOpE'(o);
    fmt <= (o == 2'd1) ? fpFormatPkg::fmtPairSingle :
           (lfsrBit() ? fpFormatPkg::fmtDouble : fpFormatPkg::fmtSingle);
    cond    <= cmpOpPkg::condE'(randBits(2));
    srchSz  <= randBits(2);
    inValid <= 1'b1;
  endtask

  task automatic randomTraffic();
    int sent, got, cycles;
    logic takeIn, takeOut;
    logic [69:0] exp;
    sent = 0;
    got = 0;
    cycles = 0;
    expQ.delete();
    @(posedge clk);
    driveRandom();
    outReady <= lfsrBit();
    while (got < TrafficCount && cycles < TrafficLimit) begin
      @(negedge clk);
      cycles++;
      takeIn  = inValid && inReady;
      takeOut = outValid && outReady;
      if (takeOut) begin
        assert (expQ.size() > 0) else begin
          $display("a result came out with no request pending");
          errors++;
        end
        if (expQ.size() > 0) begin
          exp = expQ.pop_front();
          checkHex("resData", exp[63:0], resData);
          checkHex("resFlags", exp[69:64], resFlags);
          got++;
        end
      end
      if (takeIn) begin
        expQ.push_back(refResult(opA, opB, fmt, op, cond, srchSz));
        sent++;
      end
      @(posedge clk);
      if (takeIn && sent < TrafficCount) driveRandom();
      else if (takeIn) inValid <= 1'b0;
      outReady <= lfsrBit();
    end
    if (got < TrafficCount) begin
      $display("timeout: only %0d of %0d results came out", got, TrafficCount);
      timeouts++;
    end
    inValid  <= 1'b0;
    outReady <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      assert (!outValid) else begin
        $display("an extra result came out after the traffic ended");
        errors++;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    outReady = 1'b0;
    opA = '0;
    opB = '0;
    fmt = fpFormatPkg::fmtSingle;
    op = cmpOpPkg::opCmpScalar;
    cond = cmpOpPkg::condGe;
    srchSz = '0;
    lfsr = 32'h3977;
    errors = 0;
    checks = 0;
    timeouts = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    resetState();
    scalarCompares();
    unorderedCases();
    vectorMasks();
    searchCases();
    randomTraffic();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: fcmpUnit.f
hw/fpFormatPkg.sv
hw/cmpOpPkg.sv
hw/fcmpIf.sv
hw/bitFindFirst.sv
hw/fcmpOperandUnpack.sv
hw/fcmpCore.sv
hw/fcmpResultPack.sv
hw/fcmpUnit.sv
tb/fcmpUnitTb.sv

// File: Bender.yml
package:
  name: fcmpUnit

sources:
  - hw/fpFormatPkg.sv
  - hw/cmpOpPkg.sv
  - hw/fcmpIf.sv
  - hw/bitFindFirst.sv
  - hw/fcmpOperandUnpack.sv
  - hw/fcmpCore.sv
  - hw/fcmpResultPack.sv
  - hw/fcmpUnit.sv
  - target: test
    files:
      - tb/fcmpUnitTb.sv
